// File: Makefile
# Verilator build and run of the cache directory testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cache_top_tb
FILELIST = cache_top.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: cache_top.f
+incdir+source
source/cache_pkg.sv
source/way_lookup.sv
source/lru_update.sv
source/mesi_controller.sv
source/tag_mesi_store.sv
source/access_stats.sv
source/cache_top.sv
verif/cache_top_assert.sv
verif/cache_top_tb.sv

// File: source/access_stats.sv
/*
 * Access statistics
 * Hit, miss, read and write counters
 */
`include "cache_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module access_stats (
	input  logic                         Clock,
	input  logic                         rst_n,
	input  logic                         clear,
	input  cache_pkg::cache_req_t        req,
	input  logic                         is_hit,
	input  logic                         is_miss,
	output logic [`CACHE_STAT_BITS-1:0]  hits,
	output logic [`CACHE_STAT_BITS-1:0]  misses,
	output logic [`CACHE_STAT_BITS-1:0]  reads,
	output logic [`CACHE_STAT_BITS-1:0]  writes
);

	logic is_read;
	logic is_write;

	assign is_read  = req.valid && (req.cmd == cache_pkg::CMD_READ);
	assign is_write = req.valid && (req.cmd == cache_pkg::CMD_WRITE);

	always_ff @(posedge Clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hits   <= '0;
			misses <= '0;
			reads  <= '0;
			writes <= '0;
		end
		else if (clear)
		begin
			hits   <= '0;
			misses <= '0;
			reads  <= '0;
			writes <= '0;
		end
		else
		begin
			hits   <= hits + is_hit;
			misses <= misses + is_miss;
			reads  <= reads + is_read;
			writes <= writes + is_write;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_macros.svh
/*
 * L1 data-cache directory geometry
 * Set count, way count and the field widths derived from them
 */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Associativity and set count
`define CACHE_WAYS 4
`define CACHE_SETS 64
`define CACHE_WAY_BITS $clog2(`CACHE_WAYS)

// Address split of a 32-bit byte address
`define CACHE_INDEX_BITS 6
`define CACHE_OFFSET_BITS 6
`define CACHE_TAG_BITS (32 - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

// Line address sent to L2 is tag joined with index
`define CACHE_LINE_BITS (`CACHE_TAG_BITS + `CACHE_INDEX_BITS)

// Statistics counter width
`define CACHE_STAT_BITS 32

`endif

// File: source/cache_pkg.sv
/*
 * Cache directory types
 * Commands, MESI states, L2 operations, address word and bus structs
 */
`include "cache_macros.svh"
`default_nettype none

package cache_pkg;

	// Command codes as issued by the trace source
	typedef enum logic [3:0] {
		CMD_READ       = 4'd0,
		CMD_WRITE      = 4'd1,
		CMD_INVALIDATE = 4'd3,
		CMD_SNOOP      = 4'd4,
		CMD_RESET      = 4'd8
	} cache_cmd_e;

	typedef enum logic [1:0] {
		MESI_INVALID   = 2'd0,
		MESI_SHARED    = 2'd1,
		MESI_EXCLUSIVE = 2'd2,
		MESI_MODIFIED  = 2'd3
	} mesi_e;

	// Requests toward the shared L2
	typedef enum logic [1:0] {
		L2_NONE  = 2'd0,
		L2_READ  = 2'd1,
		L2_WRITE = 2'd2,
		L2_RWITM = 2'd3
	} l2_op_e;

	// Way number, also wide enough for a counter-LRU value
	typedef logic [`CACHE_WAY_BITS-1:0] way_idx_t;

	typedef struct packed {
		logic [`CACHE_TAG_BITS-1:0]    tag;
		logic [`CACHE_INDEX_BITS-1:0]  index;
		logic [`CACHE_OFFSET_BITS-1:0] offset;
	} cache_addr_fields_t;

	// Same 32-bit word seen raw or split into fields
	typedef union packed {
		logic [31:0]        raw;
		cache_addr_fields_t fields;
	} cache_addr_u;

	typedef struct packed {
		logic        valid;
		cache_cmd_e  cmd;
		cache_addr_u addr;
	} cache_req_t;

	typedef struct packed {
		l2_op_e                      op;
		logic [`CACHE_LINE_BITS-1:0] line;
		logic                        evict_valid;
		logic [`CACHE_LINE_BITS-1:0] evict_line;
	} l2_req_t;

	typedef struct packed {
		logic [`CACHE_TAG_BITS-1:0] tag;
		mesi_e                      state;
	} way_state_t;

endpackage

`default_nettype wire

// File: source/cache_top.sv
/*
 * L1 data-cache directory top
 * Lookup, MESI control, LRU and store, with a registered L2 request
 */
`include "cache_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cache_top (
	input  logic                        Clock,
	input  logic                        rst_n,
	input  cache_pkg::cache_req_t       req,
	output cache_pkg::l2_req_t          l2_req,
	output logic [`CACHE_STAT_BITS-1:0] hits,
	output logic [`CACHE_STAT_BITS-1:0] misses,
	output logic [`CACHE_STAT_BITS-1:0] reads,
	output logic [`CACHE_STAT_BITS-1:0] writes
);

	cache_pkg::way_state_t [`CACHE_WAYS-1:0] set_state;
	cache_pkg::way_idx_t [`CACHE_WAYS-1:0]   set_lru;
	cache_pkg::way_idx_t [`CACHE_WAYS-1:0]   next_lru;
	logic                                    hit;
	cache_pkg::way_idx_t                     hit_way;
	logic                                    invalid_found;
	cache_pkg::way_idx_t                     invalid_way;
	cache_pkg::way_idx_t                     victim_way;
	cache_pkg::way_idx_t                     target_way;
	logic                                    write_en;
	cache_pkg::way_state_t                   next_state;
	logic                                    touch;
	cache_pkg::l2_req_t                      l2_next;
	logic                                    is_hit;
	logic                                    is_miss;
	logic                                    clear;

	// Reset command wipes directory and counters
	assign clear = req.valid && (req.cmd == cache_pkg::CMD_RESET);

	tag_mesi_store u_store (
		.Clock(Clock), .rst_n(rst_n), .clear(clear),
		.index(req.addr.fields.index), .write_en(write_en), .target_way(target_way),
		.next_state(next_state), .touch(touch), .next_lru(next_lru),
		.set_state(set_state), .set_lru(set_lru)
	);

	way_lookup u_lookup (
		.set_state(set_state), .set_lru(set_lru), .tag(req.addr.fields.tag),
		.hit(hit), .hit_way(hit_way), .invalid_found(invalid_found),
		.invalid_way(invalid_way), .victim_way(victim_way)
	);

	mesi_controller u_ctrl (
		.req(req), .set_state(set_state), .hit(hit), .hit_way(hit_way),
		.invalid_found(invalid_found), .invalid_way(invalid_way),
		.victim_way(victim_way), .target_way(target_way), .write_en(write_en),
		.next_state(next_state), .touch(touch), .l2_next(l2_next),
		.is_hit(is_hit), .is_miss(is_miss)
	);

	lru_update u_lru (.set_lru(set_lru), .touch_way(target_way), .next_lru(next_lru));

	access_stats u_stats (
		.Clock(Clock), .rst_n(rst_n), .clear(clear), .req(req),
		.is_hit(is_hit), .is_miss(is_miss),
		.hits(hits), .misses(misses), .reads(reads), .writes(writes)
	);

	// L2 request one cycle after the strobe, op none when idle
	always_ff @(posedge Clock or negedge rst_n)
	begin
		if (!rst_n)
			l2_req <= '0;
		else
			l2_req <= l2_next;
	end

endmodule

`default_nettype wire

// File: source/lru_update.sv
/*
 * Counter LRU update for one set
 * Touched way becomes newest, younger ways age by one
 */
`include "cache_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module lru_update (
	input  cache_pkg::way_idx_t [`CACHE_WAYS-1:0] set_lru,
	input  cache_pkg::way_idx_t                   touch_way,
	output cache_pkg::way_idx_t [`CACHE_WAYS-1:0] next_lru
);

	cache_pkg::way_idx_t touched_age;

	assign touched_age = set_lru[touch_way];

	always_comb
	begin
		for (int w = 0; w < `CACHE_WAYS; w++)
		begin
			if (cache_pkg::way_idx_t'(w) == touch_way)
				next_lru[w] = '0;
			else if (set_lru[w] < touched_age)
				next_lru[w] = set_lru[w] + 1'b1;
			else
				// Older than the touched way, order kept
				next_lru[w] = set_lru[w];
		end
	end

endmodule

`default_nettype wire

// File: source/mesi_controller.sv
/*
 * MESI controller
 * Per-command state transition, target way choice and L2 request
 */
`include "cache_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module mesi_controller (
	input  cache_pkg::cache_req_t                   req,
	input  cache_pkg::way_state_t [`CACHE_WAYS-1:0] set_state,
	input  logic                                    hit,
	input  cache_pkg::way_idx_t                     hit_way,
	input  logic                                    invalid_found,
	input  cache_pkg::way_idx_t                     invalid_way,
	input  cache_pkg::way_idx_t                     victim_way,
	output cache_pkg::way_idx_t                     target_way,
	output logic                                    write_en,
	output cache_pkg::way_state_t                   next_state,
	output logic                                    touch,
	output cache_pkg::l2_req_t                      l2_next,
	output logic                                    is_hit,
	output logic                                    is_miss
);

	cache_pkg::way_state_t       cur;
	logic [`CACHE_LINE_BITS-1:0] req_line;
	logic [`CACHE_LINE_BITS-1:0] victim_line;

	// Hit way first, else a free way, else the LRU victim
	assign target_way = hit ? hit_way : (invalid_found ? invalid_way : victim_way);
	assign cur        = set_state[target_way];

	assign req_line    = req.addr.raw[31 -: `CACHE_LINE_BITS];
	assign victim_line = {cur.tag, req.addr.fields.index};

	//////////////////////////////
	// Command table
	//////////////////////////////
	always_comb
	begin
		write_en   = 1'b0;
		next_state = cur;
		touch      = 1'b0;
		l2_next    = '0;
		is_hit     = 1'b0;
		is_miss    = 1'b0;

		if (req.valid)
		begin
			case (req.cmd)
				cache_pkg::CMD_READ:
				begin
					touch = 1'b1;
					if (hit)
						is_hit = 1'b1;
					else
					begin
						// Fill as Shared, write back a dirty victim
						is_miss          = 1'b1;
						write_en         = 1'b1;
						next_state.tag   = req.addr.fields.tag;
						next_state.state = cache_pkg::MESI_SHARED;
						l2_next.op       = cache_pkg::L2_READ;
						l2_next.line     = req_line;
						if (cur.state == cache_pkg::MESI_MODIFIED)
						begin
							l2_next.evict_valid = 1'b1;
							l2_next.evict_line  = victim_line;
						end
					end
				end

				cache_pkg::CMD_WRITE:
				begin
					touch    = 1'b1;
					write_en = 1'b1;
					if (hit)
					begin
						is_hit = 1'b1;
						if (cur.state == cache_pkg::MESI_SHARED)
						begin
							// First write goes through to L2
							next_state.state = cache_pkg::MESI_EXCLUSIVE;
							l2_next.op       = cache_pkg::L2_WRITE;
							l2_next.line     = req_line;
						end
						else
							next_state.state = cache_pkg::MESI_MODIFIED;
					end
					else
					begin
						is_miss          = 1'b1;
						next_state.tag   = req.addr.fields.tag;
						next_state.state = cache_pkg::MESI_MODIFIED;
						l2_next.op       = cache_pkg::L2_RWITM;
						l2_next.line     = req_line;
						if (cur.state == cache_pkg::MESI_MODIFIED)
						begin
							l2_next.evict_valid = 1'b1;
							l2_next.evict_line  = victim_line;
						end
					end
				end

				cache_pkg::CMD_INVALIDATE:
				begin
					if (hit)
					begin
						touch            = 1'b1;
						write_en         = 1'b1;
						next_state.state = cache_pkg::MESI_INVALID;
						if (cur.state == cache_pkg::MESI_MODIFIED)
						begin
							l2_next.op   = cache_pkg::L2_WRITE;
							l2_next.line = req_line;
						end
					end
				end

				cache_pkg::CMD_SNOOP:
				begin
					if (hit)
					begin
						touch = 1'b1;
						// Owned copy is returned and demoted
						if (cur.state == cache_pkg::MESI_EXCLUSIVE ||
							cur.state == cache_pkg::MESI_MODIFIED)
						begin
							write_en         = 1'b1;
							next_state.state = cache_pkg::MESI_SHARED;
							l2_next.op       = cache_pkg::L2_WRITE;
							l2_next.line     = req_line;
						end
					end
				end

				// Reset is handled as a clear in the top level
				default:
				begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/tag_mesi_store.sv
/*
 * Tag, MESI and LRU store
 * Flip-flop arrays for all sets, one set read combinationally
 */
`include "cache_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module tag_mesi_store (
	input  logic                                    Clock,
	input  logic                                    rst_n,
	input  logic                                    clear,
	input  logic [`CACHE_INDEX_BITS-1:0]            index,
	input  logic                                    write_en,
	input  cache_pkg::way_idx_t                     target_way,
	input  cache_pkg::way_state_t                   next_state,
	input  logic                                    touch,
	input  cache_pkg::way_idx_t [`CACHE_WAYS-1:0]   next_lru,
	output cache_pkg::way_state_t [`CACHE_WAYS-1:0] set_state,
	output cache_pkg::way_idx_t [`CACHE_WAYS-1:0]   set_lru
);

	cache_pkg::way_state_t [`CACHE_WAYS-1:0] ways_q [`CACHE_SETS];
	cache_pkg::way_idx_t [`CACHE_WAYS-1:0]   lru_q  [`CACHE_SETS];

	// Combinational read of the addressed set
	assign set_state = ways_q[index];
	assign set_lru   = lru_q[index];

	//////////////////////////////
	// Update and clear
	//////////////////////////////
	always_ff @(posedge Clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < `CACHE_SETS; s++)
			begin
				for (int w = 0; w < `CACHE_WAYS; w++)
				begin
					ways_q[s][w].tag   <= '0;
					ways_q[s][w].state <= cache_pkg::MESI_INVALID;
					// Way 0 starts oldest
					lru_q[s][w]        <= cache_pkg::way_idx_t'(`CACHE_WAYS - 1 - w);
				end
			end
		end
		else if (clear)
		begin
			for (int s = 0; s < `CACHE_SETS; s++)
			begin
				for (int w = 0; w < `CACHE_WAYS; w++)
				begin
					ways_q[s][w].tag   <= '0;
					ways_q[s][w].state <= cache_pkg::MESI_INVALID;
					lru_q[s][w]        <= cache_pkg::way_idx_t'(`CACHE_WAYS - 1 - w);
				end
			end
		end
		else
		begin
			if (write_en)
				ways_q[index][target_way] <= next_state;
			if (touch)
				lru_q[index] <= next_lru;
		end
	end

endmodule

`default_nettype wire

// File: source/way_lookup.sv
/*
 * Way lookup
 * Parallel tag compare over one set, first free way and LRU victim
 */
`include "cache_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module way_lookup (
	input  cache_pkg::way_state_t [`CACHE_WAYS-1:0] set_state,
	input  cache_pkg::way_idx_t [`CACHE_WAYS-1:0]   set_lru,
	input  logic [`CACHE_TAG_BITS-1:0]              tag,
	output logic                                    hit,
	output cache_pkg::way_idx_t                     hit_way,
	output logic                                    invalid_found,
	output cache_pkg::way_idx_t                     invalid_way,
	output cache_pkg::way_idx_t                     victim_way
);

	logic [`CACHE_WAYS-1:0] match;
	logic [`CACHE_WAYS-1:0] empty;

	// Per-way match and free flags
	always_comb
	begin
		for (int w = 0; w < `CACHE_WAYS; w++)
		begin
			empty[w] = (set_state[w].state == cache_pkg::MESI_INVALID);
			match[w] = !empty[w] && (set_state[w].tag == tag);
		end
	end

	assign hit           = |match;
	assign invalid_found = |empty;

	// Walk from the top so the lowest way wins
	always_comb
	begin
		hit_way     = '0;
		invalid_way = '0;
		victim_way  = '0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--)
		begin
			if (match[w])
				hit_way = cache_pkg::way_idx_t'(w);
			if (empty[w])
				invalid_way = cache_pkg::way_idx_t'(w);
			// Oldest way holds the all-ones counter
			if (set_lru[w] == '1)
				victim_way = cache_pkg::way_idx_t'(w);
		end
	end

endmodule

`default_nettype wire

// File: verif/cache_top_assert.sv
/*
 * Cache directory protocol checks
 * Bound to the top level to watch the registered L2 request
 */
`timescale 1ns/100ps
`default_nettype none

module cache_top_assert (
	input logic                  Clock,
	input logic                  rst_n,
	input cache_pkg::cache_req_t req,
	input cache_pkg::l2_req_t    l2_req
);

	// No strobe means no L2 traffic one cycle later
	idle_no_op_a: assert property (@(posedge Clock) disable iff (!rst_n)
		!req.valid |=> (l2_req.op == cache_pkg::L2_NONE))
		else $error("L2 operation issued after a cycle without a request");

	// Write-back only rides along with a fetch
	evict_with_fetch_a: assert property (@(posedge Clock) disable iff (!rst_n)
		l2_req.evict_valid |->
			(l2_req.op == cache_pkg::L2_READ || l2_req.op == cache_pkg::L2_RWITM))
		else $error("Victim write-back without a read or rwitm fetch");

endmodule

bind cache_top cache_top_assert u_cache_top_assert (
	.Clock(Clock), .rst_n(rst_n), .req(req), .l2_req(l2_req)
);

`default_nettype wire

// File: verif/cache_top_tb.sv
/*
 * Cache directory testbench
 * Table of commands with expected L2 requests and counters, one per cycle
 */
`include "cache_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cache_top_tb;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY  = 1;
	localparam int MARGIN_NS    = 100;
	localparam logic [31:0] LFSR_SEED = 32'h19ef3848;

	// Command codes, IDLE marks a cycle without a strobe
	localparam logic [3:0] RD   = cache_pkg::CMD_READ;
	localparam logic [3:0] WR   = cache_pkg::CMD_WRITE;
	localparam logic [3:0] INV  = cache_pkg::CMD_INVALIDATE;
	localparam logic [3:0] SNP  = cache_pkg::CMD_SNOOP;
	localparam logic [3:0] RST  = cache_pkg::CMD_RESET;
	localparam logic [3:0] UNK  = 4'd2;
	localparam logic [3:0] IDLE = 4'hf;

	localparam logic [1:0] OP_NONE  = cache_pkg::L2_NONE;
	localparam logic [1:0] OP_RD    = cache_pkg::L2_READ;
	localparam logic [1:0] OP_WR    = cache_pkg::L2_WRITE;
	localparam logic [1:0] OP_RWITM = cache_pkg::L2_RWITM;

	// Statistics outcome of one entry
	localparam logic [1:0] NA   = 2'd0;
	localparam logic [1:0] HIT  = 2'd1;
	localparam logic [1:0] MISS = 2'd2;

	typedef struct packed {
		logic [3:0]                   cmd;
		logic [`CACHE_TAG_BITS-1:0]   tag;
		logic [`CACHE_INDEX_BITS-1:0] index;
		logic [1:0]                   op;
		logic                         evict;
		logic [`CACHE_TAG_BITS-1:0]   evict_tag;
		logic [1:0]                   outcome;
		logic                         check_stats;
	} entry_t;

	logic                        Clock;
	logic                        rst_n;
	cache_pkg::cache_req_t       req;
	cache_pkg::l2_req_t          l2_req;
	logic [`CACHE_STAT_BITS-1:0] hits;
	logic [`CACHE_STAT_BITS-1:0] misses;
	logic [`CACHE_STAT_BITS-1:0] reads;
	logic [`CACHE_STAT_BITS-1:0] writes;

	entry_t      table_q [$];
	string       name_q [$];
	logic        table_built = 1'b0;
	logic [31:0] lfsr_state;
	int          sum_hits;
	int          sum_misses;
	int          sum_reads;
	int          sum_writes;

	cache_top u_cache_top (
		.Clock(Clock), .rst_n(rst_n), .req(req), .l2_req(l2_req),
		.hits(hits), .misses(misses), .reads(reads), .writes(writes)
	);

	always #(CLK_PERIOD / 2) Clock = ~Clock;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic check_value(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch %s %s expected 0x%0h actual 0x%0h",
				name, field, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic add_entry(input string name, input logic [3:0] cmd,
		input logic [`CACHE_TAG_BITS-1:0] tag, input logic [`CACHE_INDEX_BITS-1:0] index,
		input logic [1:0] op, input logic evict, input logic [`CACHE_TAG_BITS-1:0] evict_tag,
		input logic [1:0] outcome, input logic check_stats);
		entry_t e;
		e.cmd         = cmd;
		e.tag         = tag;
		e.index       = index;
		e.op          = op;
		e.evict       = evict;
		e.evict_tag   = evict_tag;
		e.outcome     = outcome;
		e.check_stats = check_stats;
		table_q.push_back(e);
		name_q.push_back(name);
	endtask

	task automatic build_table();
		// Read miss then hit, then the MESI walk S to E to M to S
		add_entry("rd_miss",        RD,   20'h1,  6'd1, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		add_entry("rd_hit",         RD,   20'h1,  6'd1, OP_NONE,  1'b0, 20'h0,  HIT,  1'b0);
		add_entry("wr_shared",      WR,   20'h1,  6'd1, OP_WR,    1'b0, 20'h0,  HIT,  1'b0);
		add_entry("wr_exclusive",   WR,   20'h1,  6'd1, OP_NONE,  1'b0, 20'h0,  HIT,  1'b0);
		add_entry("snoop_modified", SNP,  20'h1,  6'd1, OP_WR,    1'b0, 20'h0,  NA,   1'b0);
		add_entry("snoop_shared",   SNP,  20'h1,  6'd1, OP_NONE,  1'b0, 20'h0,  NA,   1'b0);
		add_entry("unknown_cmd",    UNK,  20'h1,  6'd1, OP_NONE,  1'b0, 20'h0,  NA,   1'b0);
		// Five tags into set 2, reset order evicts way 0
		add_entry("fill_way0",      RD,   20'h10, 6'd2, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		add_entry("fill_way1",      RD,   20'h11, 6'd2, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		add_entry("fill_way2",      RD,   20'h12, 6'd2, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		add_entry("fill_way3",      RD,   20'h13, 6'd2, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		add_entry("evict_lru",      RD,   20'h14, 6'd2, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		add_entry("keep_way1",      RD,   20'h11, 6'd2, OP_NONE,  1'b0, 20'h0,  HIT,  1'b0);
		add_entry("refetch_way0",   RD,   20'h10, 6'd2, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		// Write misses leave set 3 all Modified
		add_entry("wmiss_way0",     WR,   20'h20, 6'd3, OP_RWITM, 1'b0, 20'h0,  MISS, 1'b0);
		add_entry("wmiss_way1",     WR,   20'h21, 6'd3, OP_RWITM, 1'b0, 20'h0,  MISS, 1'b0);
		add_entry("wmiss_way2",     WR,   20'h22, 6'd3, OP_RWITM, 1'b0, 20'h0,  MISS, 1'b0);
		add_entry("wmiss_way3",     WR,   20'h23, 6'd3, OP_RWITM, 1'b0, 20'h0,  MISS, 1'b0);
		add_entry("evict_dirty",    RD,   20'h24, 6'd3, OP_RD,    1'b1, 20'h20, MISS, 1'b0);
		add_entry("inv_modified",   INV,  20'h21, 6'd3, OP_WR,    1'b0, 20'h0,  NA,   1'b0);
		add_entry("rd_after_inv",   RD,   20'h21, 6'd3, OP_RD,    1'b0, 20'h0,  MISS, 1'b1);
		// Reset command wipes lines and counters
		add_entry("reset_cmd",      RST,  20'h0,  6'd0, OP_NONE,  1'b0, 20'h0,  NA,   1'b1);
		add_entry("rd_after_reset", RD,   20'h1,  6'd1, OP_RD,    1'b0, 20'h0,  MISS, 1'b0);
		add_entry("idle_final",     IDLE, 20'h0,  6'd0, OP_NONE,  1'b0, 20'h0,  NA,   1'b1);
	endtask

	task automatic drive_entry(input entry_t e);
		cache_pkg::cache_req_t        r;
		logic [`CACHE_OFFSET_BITS-1:0] offset;
		// Random offset, the line address must not depend on it
		for (int b = 0; b < `CACHE_OFFSET_BITS; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			offset[b]  = lfsr_state[0];
		end
		r.valid              = (e.cmd != IDLE);
		r.cmd                = cache_pkg::cache_cmd_e'(e.cmd);
		r.addr.fields.tag    = e.tag;
		r.addr.fields.index  = e.index;
		r.addr.fields.offset = offset;
		req = r;
	endtask

	task automatic check_entry(input int i);
		entry_t                      e;
		string                       name;
		logic [`CACHE_LINE_BITS-1:0] exp_line;
		logic [`CACHE_LINE_BITS-1:0] exp_evict;
		e    = table_q[i];
		name = name_q[i];
		// Line address is tag joined with index, zero when nothing is sent
		exp_line  = (e.op != OP_NONE) ? {e.tag, e.index} : '0;
		exp_evict = e.evict ? {e.evict_tag, e.index} : '0;
		if (e.cmd == RST)
		begin
			sum_hits   = 0;
			sum_misses = 0;
			sum_reads  = 0;
			sum_writes = 0;
		end
		else
		begin
			if (e.cmd == RD)
				sum_reads++;
			if (e.cmd == WR)
				sum_writes++;
			if (e.outcome == HIT)
				sum_hits++;
			if (e.outcome == MISS)
				sum_misses++;
		end
		check_value(name, "op", 32'(e.op), 32'(l2_req.op));
		check_value(name, "line", 32'(exp_line), 32'(l2_req.line));
		check_value(name, "evict_valid", 32'(e.evict), 32'(l2_req.evict_valid));
		check_value(name, "evict_line", 32'(exp_evict), 32'(l2_req.evict_line));
		if (e.check_stats)
		begin
			check_value(name, "hits", 32'(sum_hits), 32'(hits));
			check_value(name, "misses", 32'(sum_misses), 32'(misses));
			check_value(name, "reads", 32'(sum_reads), 32'(reads));
			check_value(name, "writes", 32'(sum_writes), 32'(writes));
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial
	begin
		Clock      = 1'b0;
		rst_n      = 1'b0;
		req        = '0;
		lfsr_state = LFSR_SEED;
		sum_hits   = 0;
		sum_misses = 0;
		sum_reads  = 0;
		sum_writes = 0;
		build_table();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge Clock);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		// Each entry is checked while the next one is driven
		for (int i = 0; i <= table_q.size(); i++)
		begin
			@(posedge Clock);
			#DRIVE_DELAY;
			if (i > 0)
				check_entry(i - 1);
			if (i < table_q.size())
				drive_entry(table_q[i]);
			else
				req = '0;
		end
		$display("TEST OK");
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (table_built);
		#((table_q.size() + RESET_CYCLES + 2) * CLK_PERIOD + MARGIN_NS);
		$display("Timeout: the command table did not finish in time");
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire
